/* Bender.yml */
package:
  name: msx_slot_bus

sources:
  # Package first, then the modules bottom up
  - logic/msx_pkg.sv
  - logic/slot_bus_decoder.sv
  - logic/slot_unit.sv
  - logic/slot_merge.sv
  - logic/msx_slot_bus.sv
  - target: simulation
    files:
      - verification/tb_ram_model.sv
      - verification/tb_msx_slot_bus.sv

/* flist.f */
logic/msx_pkg.sv
logic/slot_bus_decoder.sv
logic/slot_unit.sv
logic/slot_merge.sv
logic/msx_slot_bus.sv
verification/tb_ram_model.sv
verification/tb_msx_slot_bus.sv

/* logic/msx_pkg.sv */
package msx_pkg;

   // Memory system geometry
   localparam int unsigned num_slots = 4;
   localparam int unsigned ram_aw = 27;
   localparam int unsigned page_bits = 14;
   localparam int unsigned base_bits = ram_aw - page_bits;

   // PPI sits at A8h..ABh, port A is offset 0
   localparam logic [7:0] ppi_port_base = 8'hA8;

   // Floating data bus reads back as all ones
   localparam logic [7:0] empty_data = 8'hFF;

   typedef enum logic [1:0] {
      blk_none = 2'd0,
      blk_rom  = 2'd1,
      blk_ram  = 2'd2
   } block_kind_t;

   // One 16 KB page of a slot
   typedef struct packed {
      block_kind_t          kind;
      logic [base_bits-1:0] base;
   } page_map_t;

   // Indexed by CPU page, addr[15:14]
   typedef page_map_t [3:0] slot_layout_t;

   typedef struct packed {
      logic        valid;
      logic        rd;
      logic        wr;
      logic        iorq;
      logic        m1;
      logic [15:0] addr;
      logic [7:0]  data;
   } cpu_req_t;

   typedef struct packed {
      logic                 valid;
      logic                 rd;
      logic                 wr;
      logic                 io;
      logic [7:0]           io_data;
      logic [1:0]           slot;
      logic [1:0]           page;
      logic [page_bits-1:0] offset;
      logic [7:0]           data;
   } dec_req_t;

   typedef struct packed {
      logic              ce;
      logic              rnw;
      logic [ram_aw-1:0] addr;
      logic [7:0]        din;
   } ram_req_t;

   typedef struct packed {
      logic     hit;
      ram_req_t ram;
   } slot_out_t;

   typedef struct packed {
      logic       valid;
      logic [7:0] data;
   } cpu_resp_t;

endpackage

/* logic/msx_slot_bus.sv */
module msx_slot_bus (
   input  logic                  clock_bus,
   input  logic                  reset,
   input  msx_pkg::cpu_req_t     cpu_req,
   output msx_pkg::cpu_resp_t    cpu_resp,
   input  msx_pkg::slot_layout_t slot_layout [msx_pkg::num_slots],
   output msx_pkg::ram_req_t     ram_req,
   input  logic [7:0]            ram_dout,
   output logic [7:0]            slot_reg,
   output logic                  wait_n
);

   msx_pkg::dec_req_t  dec_req;
   msx_pkg::slot_out_t slot_out [msx_pkg::num_slots];

   // I/O decode, slot register and M1 wait
   slot_bus_decoder slot_bus_decoder_i (
      .clock_bus (clock_bus),
      .reset     (reset),
      .cpu_req   (cpu_req),
      .dec_req   (dec_req),
      .slot_reg  (slot_reg),
      .wait_n    (wait_n)
   );

   // One unit per primary slot
   for (genvar i = 0; i < msx_pkg::num_slots; i++) begin : g_slot
      slot_unit #(
         .slot_id (i)
      ) slot_unit_i (
         .clock_bus (clock_bus),
         .reset     (reset),
         .layout    (slot_layout[i]),
         .dec_req   (dec_req),
         .slot_out  (slot_out[i])
      );
   end

   // External memory port and CPU read data
   slot_merge slot_merge_i (
      .clock_bus (clock_bus),
      .reset     (reset),
      .dec_req   (dec_req),
      .slot_out  (slot_out),
      .ram_req   (ram_req),
      .ram_dout  (ram_dout),
      .cpu_resp  (cpu_resp)
   );

endmodule

/* logic/slot_bus_decoder.sv */
module slot_bus_decoder (
   input  logic              clock_bus,
   input  logic              reset,
   input  msx_pkg::cpu_req_t cpu_req,
   output msx_pkg::dec_req_t dec_req,
   output logic [7:0]        slot_reg,
   output logic              wait_n
);

   logic       ppi_sel;
   logic       port_a_sel;
   logic       port_a_wr;
   logic       map_valid;
   logic [1:0] page;
   logic [1:0] page_slot;
   logic [1:0] active_slot;

   // PPI window A8h..AB, interrupt acknowledge never hits it
   assign ppi_sel = cpu_req.iorq & ~cpu_req.m1 &
                    (cpu_req.addr[7:2] == msx_pkg::ppi_port_base[7:2]);

   assign port_a_sel = ppi_sel & (cpu_req.addr[1:0] == msx_pkg::ppi_port_base[1:0]);
   assign port_a_wr  = cpu_req.valid & cpu_req.wr & port_a_sel;

   assign page = cpu_req.addr[15:14];

   // Two bits of the slot register per page
   always_comb begin
      case (page)
         2'd0:    page_slot = slot_reg[1:0];
         2'd1:    page_slot = slot_reg[3:2];
         2'd2:    page_slot = slot_reg[5:4];
         default: page_slot = slot_reg[7:6];
      endcase
   end

   // Whole map sits in slot 0 until the register is first written
   assign active_slot = map_valid ? page_slot : 2'b00;

   // Primary slot register
   always_ff @(posedge clock_bus or posedge reset) begin
      if (reset) begin
         slot_reg  <= '0;
         map_valid <= 1'b0;
      end else if (port_a_wr) begin
         slot_reg  <= cpu_req.data;
         map_valid <= 1'b1;
      end
   end

   // Decoded request stage
   always_ff @(posedge clock_bus or posedge reset) begin
      if (reset) begin
         dec_req <= '0;
      end else begin
         dec_req.valid  <= cpu_req.valid;
         dec_req.rd     <= cpu_req.rd;
         dec_req.wr     <= cpu_req.wr;
         dec_req.io     <= cpu_req.iorq;
         dec_req.slot   <= active_slot;
         dec_req.page   <= page;
         dec_req.offset <= cpu_req.addr[msx_pkg::page_bits-1:0];
         dec_req.data   <= cpu_req.data;
         // Port A reads back the register, anything else floats
         if (cpu_req.rd && port_a_sel) begin
            dec_req.io_data <= slot_reg;
         end else begin
            dec_req.io_data <= msx_pkg::empty_data;
         end
      end
   end

   // One wait state per M1 cycle
   always_ff @(posedge clock_bus or posedge reset) begin
      if (reset) begin
         wait_n <= 1'b1;
      end else begin
         wait_n <= ~(cpu_req.valid & cpu_req.m1);
      end
   end

endmodule

/* logic/slot_merge.sv */
module slot_merge (
   input  logic               clock_bus,
   input  logic               reset,
   input  msx_pkg::dec_req_t  dec_req,
   input  msx_pkg::slot_out_t slot_out [msx_pkg::num_slots],
   output msx_pkg::ram_req_t  ram_req,
   input  logic [7:0]         ram_dout,
   output msx_pkg::cpu_resp_t cpu_resp
);

   logic       any_hit;
   logic       rd_q1;
   logic       rd_q2;
   logic       hit_q2;
   logic [7:0] data_q1;
   logic [7:0] data_q2;

   // Only one slot drives a request at a time, so a plain OR does
   always_comb begin
      ram_req = '0;
      any_hit = 1'b0;
      for (int i = 0; i < msx_pkg::num_slots; i++) begin
         ram_req = ram_req | slot_out[i].ram;
         any_hit = any_hit | slot_out[i].hit;
      end
   end

   // Read tag, lined up with the slot stage and then the memory
   always_ff @(posedge clock_bus or posedge reset) begin
      if (reset) begin
         rd_q1  <= 1'b0;
         rd_q2  <= 1'b0;
         hit_q2 <= 1'b0;
      end else begin
         rd_q1  <= dec_req.valid & dec_req.rd;
         rd_q2  <= rd_q1;
         hit_q2 <= any_hit;
      end
   end

   // I/O data, or FFh for an empty page
   always_ff @(posedge clock_bus) begin
      data_q1 <= dec_req.io_data;
      data_q2 <= data_q1;
   end

   // Response four cycles after the request
   always_ff @(posedge clock_bus or posedge reset) begin
      if (reset) begin
         cpu_resp <= '0;
      end else begin
         cpu_resp.valid <= rd_q2;
         if (hit_q2) begin
            cpu_resp.data <= ram_dout;
         end else begin
            cpu_resp.data <= data_q2;
         end
      end
   end

endmodule

/* logic/slot_unit.sv */
module slot_unit #(
   parameter int unsigned slot_id = 0
) (
   input  logic                  clock_bus,
   input  logic                  reset,
   input  msx_pkg::slot_layout_t layout,
   input  msx_pkg::dec_req_t     dec_req,
   output msx_pkg::slot_out_t    slot_out
);

   msx_pkg::page_map_t page_map;
   logic               selected;
   logic               page_used;
   logic               serve_rd;
   logic               serve_wr;

   assign page_map = layout[dec_req.page];

   // Memory cycle aimed at this primary slot
   assign selected = dec_req.valid & ~dec_req.io & (dec_req.slot == 2'(slot_id));

   assign page_used = (page_map.kind == msx_pkg::blk_rom) ||
                      (page_map.kind == msx_pkg::blk_ram);

   // ROM pages silently drop writes
   assign serve_rd = selected & dec_req.rd & page_used;
   assign serve_wr = selected & dec_req.wr & (page_map.kind == msx_pkg::blk_ram);

   // Idle output stays all zero so the merge can OR the slots together
   always_ff @(posedge clock_bus or posedge reset) begin
      if (reset) begin
         slot_out <= '0;
      end else if (serve_rd || serve_wr) begin
         slot_out.hit      <= serve_rd;
         slot_out.ram.ce   <= 1'b1;
         slot_out.ram.rnw  <= serve_rd;
         slot_out.ram.addr <= {page_map.base, dec_req.offset};
         if (serve_wr) begin
            slot_out.ram.din <= dec_req.data;
         end else begin
            slot_out.ram.din <= 8'h00;
         end
      end else begin
         slot_out <= '0;
      end
   end

endmodule

/* verification/tb_msx_slot_bus.sv */
module tb_msx_slot_bus;

   timeunit 1ns;
   timeprecision 1ps;

   typedef struct packed {
      logic              rd;
      logic              m1;
      logic [7:0]        data;
      msx_pkg::ram_req_t ram;
   } expect_t;

   logic                  clock_bus;
   logic                  reset;
   msx_pkg::cpu_req_t     cpu_req;
   msx_pkg::cpu_resp_t    cpu_resp;
   msx_pkg::slot_layout_t slot_layout [msx_pkg::num_slots];
   msx_pkg::ram_req_t     ram_req;
   logic [7:0]            ram_dout;
   logic [7:0]            slot_reg;
   logic                  wait_n;

   int         errors = 0;
   int         seed = 32'h90d9;
   logic [7:0] ref_mem [65536];
   logic [7:0] ref_slot_reg;
   logic       ref_map_valid;
   // Stage k holds the request sampled k edges ago
   expect_t    pipe [4];

   msx_slot_bus msx_slot_bus_i (
      .clock_bus   (clock_bus),
      .reset       (reset),
      .cpu_req     (cpu_req),
      .cpu_resp    (cpu_resp),
      .slot_layout (slot_layout),
      .ram_req     (ram_req),
      .ram_dout    (ram_dout),
      .slot_reg    (slot_reg),
      .wait_n      (wait_n)
   );

   tb_ram_model ram_model_i (
      .clock_bus (clock_bus),
      .ram_req   (ram_req),
      .ram_dout  (ram_dout)
   );

   initial begin
      clock_bus = 1'b0;
      forever #10 clock_bus = ~clock_bus;
   end

   // Same content as the memory model starts with
   initial begin
      for (int a = 0; a < 65536; a++) begin
         ref_mem[a] = 8'(a) ^ 8'(a >> 8) ^ 8'h3C;
      end
   end

   task automatic report_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
      errors++;
      $display("ERR %0t %s expected %0h actual %0h", $time, name, expected, actual);
   endtask

   // Expected bus activity for one request, from the slot map rules
   function automatic expect_t predict(input msx_pkg::cpu_req_t r);
      expect_t            e;
      logic [1:0]         page;
      logic [1:0]         slot;
      msx_pkg::page_map_t pm;
      e = '0;
      page = r.addr[15:14];
      slot = ref_map_valid ? ref_slot_reg[2 * page +: 2] : 2'd0;
      pm = slot_layout[slot][page];
      if (r.valid) begin
         e.rd = r.rd;
         e.m1 = r.m1;
         e.data = msx_pkg::empty_data;
         if (r.iorq) begin
            if (r.addr[7:0] == msx_pkg::ppi_port_base) begin
               e.data = ref_slot_reg;
            end
         end else if (pm.kind == msx_pkg::blk_ram || (pm.kind == msx_pkg::blk_rom && r.rd)) begin
            e.ram.ce = 1'b1;
            e.ram.rnw = r.rd;
            e.ram.addr = {pm.base, r.addr[13:0]};
            e.ram.din = r.rd ? 8'h00 : r.data;
            if (r.rd) begin
               e.data = ref_mem[e.ram.addr[15:0]];
            end
         end
      end
      return e;
   endfunction

   always @(posedge clock_bus or posedge reset) begin
      expect_t e;
      e = predict(cpu_req);
      if (reset) begin
         for (int k = 0; k < 4; k++) begin
            pipe[k] <= '0;
         end
         ref_slot_reg <= 8'h00;
         ref_map_valid <= 1'b0;
      end else begin
         pipe[0] <= e;
         for (int k = 1; k < 4; k++) begin
            pipe[k] <= pipe[k-1];
         end
         if (cpu_req.valid && cpu_req.wr && cpu_req.iorq &&
             cpu_req.addr[7:0] == msx_pkg::ppi_port_base) begin
            ref_slot_reg <= cpu_req.data;
            ref_map_valid <= 1'b1;
         end
         if (e.ram.ce && !e.ram.rnw) begin
            ref_mem[e.ram.addr[15:0]] <= e.ram.din;
         end
      end
   end

   resp_valid_check: assert property (@(posedge clock_bus) disable iff (reset)
         cpu_resp.valid == pipe[3].rd)
      else report_value("cpu_resp.valid", $sampled(pipe[3].rd), $sampled(cpu_resp.valid));
   resp_data_check: assert property (@(posedge clock_bus) disable iff (reset)
         pipe[3].rd |-> cpu_resp.data == pipe[3].data)
      else report_value("cpu_resp.data", $sampled(pipe[3].data), $sampled(cpu_resp.data));
   ram_ce_check: assert property (@(posedge clock_bus) disable iff (reset)
         ram_req.ce == pipe[1].ram.ce)
      else report_value("ram_req.ce", $sampled(pipe[1].ram.ce), $sampled(ram_req.ce));
   ram_rnw_check: assert property (@(posedge clock_bus) disable iff (reset)
         pipe[1].ram.ce |-> ram_req.rnw == pipe[1].ram.rnw)
      else report_value("ram_req.rnw", $sampled(pipe[1].ram.rnw), $sampled(ram_req.rnw));
   ram_addr_check: assert property (@(posedge clock_bus) disable iff (reset)
         pipe[1].ram.ce |-> ram_req.addr == pipe[1].ram.addr)
      else report_value("ram_req.addr", $sampled(pipe[1].ram.addr), $sampled(ram_req.addr));
   ram_din_check: assert property (@(posedge clock_bus) disable iff (reset)
         pipe[1].ram.ce && !pipe[1].ram.rnw |-> ram_req.din == pipe[1].ram.din)
      else report_value("ram_req.din", $sampled(pipe[1].ram.din), $sampled(ram_req.din));
   wait_check: assert property (@(posedge clock_bus) disable iff (reset)
         wait_n == !pipe[0].m1)
      else report_value("wait_n", $sampled(!pipe[0].m1), $sampled(wait_n));
   slot_reg_check: assert property (@(posedge clock_bus) disable iff (reset)
         slot_reg == ref_slot_reg)
      else report_value("slot_reg", $sampled(ref_slot_reg), $sampled(slot_reg));

   // Kind rotates over RAM, ROM, empty; low base bits follow the page
   task automatic build_layout;
      for (int s = 0; s < 4; s++) begin
         for (int p = 0; p < 4; p++) begin
            case ((s + p) % 3)
               0:       slot_layout[s][p].kind = msx_pkg::blk_ram;
               1:       slot_layout[s][p].kind = msx_pkg::blk_rom;
               default: slot_layout[s][p].kind = msx_pkg::blk_none;
            endcase
            slot_layout[s][p].base = 13'(256 + 4 * s + p);
         end
      end
   endtask

   task automatic drive(input logic rd, input logic wr, input logic iorq, input logic m1,
                        input logic [15:0] addr, input logic [7:0] data);
      @(negedge clock_bus);
      cpu_req.valid = rd | wr;
      cpu_req.rd = rd;
      cpu_req.wr = wr;
      cpu_req.iorq = iorq;
      cpu_req.m1 = m1;
      cpu_req.addr = addr;
      cpu_req.data = data;
   endtask

   function automatic logic in_flight();
      logic busy;
      busy = 1'b0;
      for (int k = 0; k < 4; k++) begin
         busy = busy | pipe[k].rd | pipe[k].ram.ce;
      end
      return busy;
   endfunction

   task automatic drain;
      int n;
      n = 0;
      while (in_flight() && n < 16) begin
         @(negedge clock_bus);
         n++;
      end
      if (in_flight()) begin
         errors++;
         $display("Timeout: requests still in flight after %0d cycles", n);
      end
   endtask

   initial begin
      logic [15:0] addr;
      logic [7:0]  data;
      logic [31:0] r;
      cpu_req = '0;
      reset = 1'b1;
      build_layout();
      repeat (4) @(negedge clock_bus);
      reset = 1'b0;

      // Before any PPI write every page sits in slot 0
      for (int p = 0; p < 4; p++) begin
         r = $random(seed);
         drive(1'b1, 1'b0, 1'b0, p == 0, {2'(p), r[13:0]}, 8'h00);
      end
      r = $random(seed);
      drive(1'b0, 1'b1, 1'b1, 1'b0, {8'h00, msx_pkg::ppi_port_base}, r[7:0]);
      drive(1'b1, 1'b0, 1'b1, 1'b0, {8'h00, msx_pkg::ppi_port_base}, 8'h00);
      for (int p = 0; p < 4; p++) begin
         r = $random(seed);
         drive(1'b1, 1'b0, 1'b0, 1'b0, {2'(p), r[13:0]}, 8'h00);
      end

      // Page p in slot p gives RAM, empty, ROM, RAM
      drive(1'b0, 1'b1, 1'b1, 1'b0, {8'h00, msx_pkg::ppi_port_base}, 8'b11_10_01_00);
      r = $random(seed);
      addr = {2'd0, r[13:0]};
      data = r[21:14];
      drive(1'b0, 1'b1, 1'b0, 1'b0, addr, data);
      drive(1'b1, 1'b0, 1'b0, 1'b0, addr, 8'h00);
      addr = {2'd2, r[29:16]};
      drive(1'b0, 1'b1, 1'b0, 1'b0, addr, ~data);
      drive(1'b1, 1'b0, 1'b0, 1'b0, addr, 8'h00);
      drive(1'b1, 1'b0, 1'b0, 1'b0, {2'd1, r[13:0]}, 8'h00);
      drive(1'b1, 1'b0, 1'b1, 1'b0, 16'h0098, 8'h00);
      drive(1'b1, 1'b0, 1'b0, 1'b1, {2'd3, r[13:0]}, 8'h00);
      drive(1'b0, 1'b0, 1'b0, 1'b0, 16'h0000, 8'h00);
      drain();

      // Mixed back to back traffic
      for (int i = 0; i < 120; i++) begin
         r = $random(seed);
         case (r[2:0])
            3'd0, 3'd1: drive(1'b1, 1'b0, 1'b0, 1'b0, r[31:16], 8'h00);
            3'd2:       drive(1'b0, 1'b1, 1'b0, 1'b0, r[31:16], r[15:8]);
            3'd3:       drive(1'b1, 1'b0, 1'b0, 1'b1, r[31:16], 8'h00);
            3'd4:       drive(1'b1, 1'b0, 1'b1, 1'b0, {8'h00, r[15:8]}, 8'h00);
            3'd5:       drive(1'b0, 1'b1, 1'b1, 1'b0, {8'h00, msx_pkg::ppi_port_base}, r[15:8]);
            3'd6:       drive(1'b1, 1'b0, 1'b1, 1'b0, {8'h00, msx_pkg::ppi_port_base}, 8'h00);
            default:    drive(1'b0, 1'b0, 1'b0, 1'b0, 16'h0000, 8'h00);
         endcase
      end
      drive(1'b0, 1'b0, 1'b0, 1'b0, 16'h0000, 8'h00);
      drain();

      $display("Checks done, errors: %0d", errors);
      if (errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

/* verification/tb_ram_model.sv */
module tb_ram_model (
   input  logic              clock_bus,
   input  msx_pkg::ram_req_t ram_req,
   output logic [7:0]        ram_dout
);

   timeunit 1ns;
   timeprecision 1ps;

   // 64 KB backing store, only the low address bits decode
   logic [7:0] mem [65536];

   // Pattern mixes both address bytes
   initial begin
      for (int a = 0; a < 65536; a++) begin
         mem[a] = 8'(a) ^ 8'(a >> 8) ^ 8'h3C;
      end
      ram_dout = 8'h00;
   end

   // Read data one cycle after the strobe
   always @(posedge clock_bus) begin
      if (ram_req.ce) begin
         if (ram_req.rnw) begin
            ram_dout <= mem[ram_req.addr[15:0]];
         end else begin
            mem[ram_req.addr[15:0]] <= ram_req.din;
         end
      end
   end

endmodule
